//--- exePkg.sv
package exePkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [31:0] cause_t; // bit 31 is the interrupt flag

	typedef enum logic [3:0]
	{
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_EQ,   // branch compares from here on
		ALU_LT,
		ALU_LTU
	} aluFn_t;

	typedef enum logic [1:0]
	{
		WB_ALU,
		WB_LINK,  // pc + 4
		WB_UPPER,
		WB_AUIPC
	} wbSel_t;

	typedef enum logic [1:0]
	{
		MODE_U = 2'd0,
		MODE_S = 2'd1,
		MODE_M = 2'd3
	} mode_t;

	// cause codes in the low 31 bits of mcause
	localparam logic [30:0] I_ADDR_MISALIGNED = 31'd0;
	localparam logic [30:0] I_ILLEGAL = 31'd2;
	localparam logic [30:0] U_CALL = 31'd8; // plus mode gives S/M call
	localparam logic [30:0] S_INT_TIMER = 31'd5;
	localparam logic [30:0] M_INT_TIMER = 31'd7;
	localparam logic [30:0] S_INT_EXT = 31'd9;
	localparam logic [30:0] M_INT_EXT = 31'd11;

endpackage

//--- alu.sv
`timescale 1ns/1ps

module alu import exePkg::*;
(
	input aluFn_t fn,
	input word_t a,
	input word_t b,
	output word_t result,
	output logic taken
);

	logic eq;
	logic lt;
	logic ltu;

	assign eq = (a == b);
	assign lt = ($signed(a) < $signed(b));
	assign ltu = (a < b);

	always_comb
	begin
		result = '0;
		taken = 1'b0;
		case (fn)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_SLL: result = a << b[4:0]; // only low five bits shift
			ALU_SLT: result = {31'b0, lt};
			ALU_SLTU: result = {31'b0, ltu};
			ALU_XOR: result = a ^ b;
			ALU_SRL: result = a >> b[4:0];
			ALU_SRA: result = word_t'($signed(a) >>> b[4:0]);
			ALU_OR: result = a | b;
			ALU_AND: result = a & b;
			ALU_EQ:
			begin
				result = {31'b0, eq};
				taken = eq;
			end
			ALU_LT:
			begin
				result = {31'b0, lt};
				taken = lt;
			end
			ALU_LTU:
			begin
				result = {31'b0, ltu};
				taken = ltu;
			end
			default: result = '0;
		endcase
	end

endmodule

//--- exeStage.sv
`timescale 1ns/1ps

module exeStage import exePkg::*;
(
	input logic clk,
	input logic nrst,
	input word_t opA,
	input word_t opB,
	input word_t bImm,
	input word_t jImm,
	input word_t uImm,
	input word_t pc,
	input regAddr_t rd,
	input logic we,
	input logic isBranch,
	input logic branchNe,
	input logic isJump,
	input logic isJumpReg,
	input logic instrMisaligned,
	input logic ecall,
	input logic illegal,
	input logic mret,
	input aluFn_t aluFn,
	input wbSel_t wbSel,
	output word_t aluRes,
	output word_t linkAddr,
	output word_t upperImm,
	output word_t auipcRes,
	output word_t pcOut,
	output word_t target,
	output regAddr_t rdOut,
	output logic weOut,
	output logic ecallOut,
	output logic illegalOut,
	output logic misalignedOut,
	output logic mretOut,
	output logic bjTaken,
	output wbSel_t wbSelOut
);

	// stage-5 registers
	word_t opA5, opB5, bImm5, jImm5, uImm5, pc5;
	regAddr_t rd5;
	logic we5, isBranch5, branchNe5, isJump5, isJumpReg5;
	logic misaligned5, ecall5, illegal5, mret5;
	aluFn_t aluFn5;
	wbSel_t wbSel5;
	logic condTrue;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			{opA5, opB5, bImm5, jImm5, uImm5, pc5} <= '0;
			rd5 <= '0;
			{we5, isBranch5, branchNe5, isJump5, isJumpReg5} <= '0;
			{misaligned5, ecall5, illegal5, mret5} <= '0;
			aluFn5 <= ALU_ADD;
			wbSel5 <= WB_ALU;
		end
		else
		begin
			{opA5, opB5, bImm5, jImm5, uImm5, pc5} <= {opA, opB, bImm, jImm, uImm, pc};
			rd5 <= rd;
			{we5, isBranch5, branchNe5, isJump5, isJumpReg5} <=
				{we, isBranch, branchNe, isJump, isJumpReg};
			{misaligned5, ecall5, illegal5, mret5} <= {instrMisaligned, ecall, illegal, mret};
			aluFn5 <= aluFn;
			wbSel5 <= wbSel;
		end
	end

	alu i_alu (.fn(aluFn5), .a(opA5), .b(opB5), .result(aluRes), .taken(condTrue));

	assign linkAddr = pc5 + 32'd4;
	assign upperImm = uImm5;
	assign auipcRes = pc5 + uImm5;

	// register jump clears bit 0 of the sum
	assign target = isJumpReg5 ? ((opA5 + opB5) & ~32'd1) :
		isJump5 ? (pc5 + jImm5) : (pc5 + bImm5);
	assign bjTaken = (isBranch5 && (condTrue ^ branchNe5)) || isJump5 || isJumpReg5;

	assign pcOut = pc5;
	assign rdOut = rd5;
	assign weOut = we5;
	assign ecallOut = ecall5;
	assign illegalOut = illegal5;
	assign misalignedOut = misaligned5;
	assign mretOut = mret5;
	assign wbSelOut = wbSel5;

endmodule

//--- retireReg.sv
`timescale 1ns/1ps

module retireReg import exePkg::*;
#(
	parameter int killCycles = 6
)
(
	input logic clk,
	input logic nrst,
	input logic trap,
	input word_t aluRes,
	input word_t linkAddr,
	input word_t upperImm,
	input word_t auipcRes,
	input word_t pc,
	input regAddr_t rd,
	input logic we,
	input logic ecall,
	input logic illegal,
	input logic misaligned,
	input logic mret,
	input wbSel_t wbSel,
	output word_t aluRes6,
	output word_t link6,
	output word_t upper6,
	output word_t auipc6,
	output word_t pc6,
	output regAddr_t rd6,
	output logic we6,
	output logic ecall6,
	output logic illegal6,
	output logic misaligned6,
	output logic mret6,
	output wbSel_t wbSel6
);

	localparam int cntWidth = (killCycles > 1) ? $clog2(killCycles) : 1;

	typedef enum logic
	{
		IDLE,
		KILLING
	} killState_t;

	killState_t state;
	logic [cntWidth-1:0] killCnt;
	logic flush;

	assign flush = trap || (state == KILLING);

	// a trap while killing does not restart the kill window
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			state <= IDLE;
			killCnt <= '0;
		end
		else if (state == IDLE)
		begin
			if (trap)
				state <= KILLING;
			killCnt <= '0;
		end
		else if (killCnt == cntWidth'(killCycles - 1))
		begin
			state <= IDLE; // last flushed edge
			killCnt <= '0;
		end
		else
			killCnt <= killCnt + 1'b1;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			{aluRes6, link6, upper6, auipc6, pc6} <= '0;
			rd6 <= '0;
			{we6, ecall6, illegal6, misaligned6, mret6} <= '0;
			wbSel6 <= WB_ALU;
		end
		else if (flush)
		begin
			{aluRes6, link6, upper6, auipc6, pc6} <= '0;
			rd6 <= '0;
			{we6, ecall6, illegal6, misaligned6, mret6} <= '0;
			wbSel6 <= WB_ALU;
		end
		else
		begin
			{aluRes6, link6, upper6, auipc6, pc6} <= {aluRes, linkAddr, upperImm, auipcRes, pc};
			rd6 <= rd;
			{we6, ecall6, illegal6, misaligned6, mret6} <= {we, ecall, illegal, misaligned, mret};
			wbSel6 <= wbSel;
		end
	end

endmodule

//--- commitStage.sv
`timescale 1ns/1ps

module commitStage import exePkg::*;
(
	input word_t aluRes6,
	input word_t link6,
	input word_t upper6,
	input word_t auipc6,
	input word_t pc6,
	input regAddr_t rd6,
	input logic we6,
	input logic ecall6,
	input logic illegal6,
	input logic misaligned6,
	input logic mret6,
	input wbSel_t wbSel6,
	input mode_t mode,
	input logic mTimer,
	input logic sTimer,
	input logic mExt,
	input logic sExt,
	input logic mTie,
	input logic sTie,
	input logic mEie,
	input logic sEie,
	output word_t wbData,
	output regAddr_t rdOut,
	output logic weOut,
	output logic trap,
	output logic mretOut,
	output cause_t mcause,
	output word_t excPc
);

	logic belowM;
	logic mTimerOn, sTimerOn, mExtOn, sExtOn;

	assign belowM = (mode == MODE_U) || (mode == MODE_S); // supervisor ints only below M
	assign mTimerOn = mTie && mTimer;
	assign sTimerOn = belowM && sTie && sTimer;
	assign mExtOn = mEie && mExt;
	assign sExtOn = belowM && sEie && sExt;

	assign trap = mTimerOn || sTimerOn || mExtOn || sExtOn ||
		misaligned6 || ecall6 || illegal6 || mret6;

	// fixed priority with interrupts first
	always_comb
	begin
		if (mExtOn)
			mcause = {1'b1, M_INT_EXT};
		else if (sExtOn)
			mcause = {1'b1, S_INT_EXT};
		else if (mTimerOn)
			mcause = {1'b1, M_INT_TIMER};
		else if (sTimerOn)
			mcause = {1'b1, S_INT_TIMER};
		else if (misaligned6)
			mcause = {1'b0, I_ADDR_MISALIGNED};
		else if (ecall6)
			mcause = {1'b0, U_CALL + {29'b0, mode}};
		else if (illegal6)
			mcause = {1'b0, I_ILLEGAL};
		else
			mcause = '0; // mret or nothing
	end

	always_comb
	begin
		case (wbSel6)
			WB_ALU: wbData = aluRes6;
			WB_LINK: wbData = link6;
			WB_UPPER: wbData = upper6;
			WB_AUIPC: wbData = auipc6;
			default: wbData = '0;
		endcase
	end

	assign rdOut = rd6;
	assign weOut = we6 && !trap;
	assign mretOut = mret6;
	assign excPc = pc6;

endmodule

//--- exeTop.sv
`timescale 1ns/1ps

module exeTop import exePkg::*;
#(
	parameter int killCycles = 6
)
(
	input logic clk,
	input logic nrst,
	input word_t opA,
	input word_t opB,
	input word_t bImm,
	input word_t jImm,
	input word_t uImm,
	input word_t pc,
	input regAddr_t rd,
	input logic we,
	input aluFn_t aluFn,
	input wbSel_t wbSel,
	input logic isBranch,
	input logic branchNe,
	input logic isJump,
	input logic isJumpReg,
	input logic instrMisaligned,
	input logic ecall,
	input logic illegal,
	input logic mret,
	input mode_t mode,
	input logic mTimer,
	input logic sTimer,
	input logic mExt,
	input logic sExt,
	input logic mTie,
	input logic sTie,
	input logic mEie,
	input logic sEie,
	output word_t wbData,
	output regAddr_t rdOut,
	output logic weOut,
	output logic bjTaken,
	output word_t target,
	output word_t excPc,
	output cause_t mcause,
	output logic trap,
	output logic mretOut
);

	// stage 5 to retire register
	word_t aluRes5, link5, upper5, auipc5, pc5;
	regAddr_t rd5;
	logic we5, ecall5, illegal5, misaligned5, mret5;
	wbSel_t wbSel5;

	// stage 6 to commit
	word_t aluRes6, link6, upper6, auipc6, pc6;
	regAddr_t rd6;
	logic we6, ecall6, illegal6, misaligned6, mret6;
	wbSel_t wbSel6;

	exeStage i_exeStage (
		.clk(clk), .nrst(nrst), .opA(opA), .opB(opB), .bImm(bImm), .jImm(jImm),
		.uImm(uImm), .pc(pc), .rd(rd), .we(we), .isBranch(isBranch), .branchNe(branchNe),
		.isJump(isJump), .isJumpReg(isJumpReg), .instrMisaligned(instrMisaligned),
		.ecall(ecall), .illegal(illegal), .mret(mret), .aluFn(aluFn), .wbSel(wbSel),
		.aluRes(aluRes5), .linkAddr(link5), .upperImm(upper5), .auipcRes(auipc5),
		.pcOut(pc5), .target(target), .rdOut(rd5), .weOut(we5), .ecallOut(ecall5),
		.illegalOut(illegal5), .misalignedOut(misaligned5), .mretOut(mret5),
		.bjTaken(bjTaken), .wbSelOut(wbSel5)
	);

	retireReg #(.killCycles(killCycles)) i_retireReg (
		.clk(clk), .nrst(nrst), .trap(trap), .aluRes(aluRes5), .linkAddr(link5),
		.upperImm(upper5), .auipcRes(auipc5), .pc(pc5), .rd(rd5), .we(we5),
		.ecall(ecall5), .illegal(illegal5), .misaligned(misaligned5), .mret(mret5),
		.wbSel(wbSel5), .aluRes6(aluRes6), .link6(link6), .upper6(upper6),
		.auipc6(auipc6), .pc6(pc6), .rd6(rd6), .we6(we6), .ecall6(ecall6),
		.illegal6(illegal6), .misaligned6(misaligned6), .mret6(mret6), .wbSel6(wbSel6)
	);

	commitStage i_commitStage (
		.aluRes6(aluRes6), .link6(link6), .upper6(upper6), .auipc6(auipc6), .pc6(pc6),
		.rd6(rd6), .we6(we6), .ecall6(ecall6), .illegal6(illegal6),
		.misaligned6(misaligned6), .mret6(mret6), .wbSel6(wbSel6), .mode(mode),
		.mTimer(mTimer), .sTimer(sTimer), .mExt(mExt), .sExt(sExt), .mTie(mTie),
		.sTie(sTie), .mEie(mEie), .sEie(sEie), .wbData(wbData), .rdOut(rdOut),
		.weOut(weOut), .trap(trap), .mretOut(mretOut), .mcause(mcause), .excPc(excPc)
	);

endmodule

//--- tbClock.sv
`timescale 1ns/1ps

module tbClock
(
	output logic clk,
	output logic nrst
);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	initial
	begin
		nrst = 1'b0;
		repeat (10) @(posedge clk);
		#1 nrst = 1'b1; // release clear of the edge
	end

endmodule

//--- exeTb.sv
`timescale 1ns/1ps

module exeTb import exePkg::*;
();

	localparam int killCycles = 6;
	localparam int numInstr = 4000;

	typedef struct packed
	{
		word_t wbData;
		word_t pc;
		word_t target;
		regAddr_t rd;
		logic we, ecall, illegal, misaligned, mret, bjTaken, isBj;
	} entry_t;

	logic clk, nrst;
	word_t opA, opB, bImm, jImm, uImm, pc;
	regAddr_t rd;
	logic we, isBranch, branchNe, isJump, isJumpReg, instrMisaligned, ecall, illegal, mret;
	aluFn_t aluFn;
	wbSel_t wbSel;
	mode_t mode;
	logic mTimer, sTimer, mExt, sExt, mTie, sTie, mEie, sEie;
	word_t wbData, target, excPc;
	regAddr_t rdOut;
	logic weOut, bjTaken, trap, mretOut;
	cause_t mcause;

	word_t lfsr = 32'd48;
	entry_t pipe[$]; // [0] is stage 6 and [1] is stage 5
	logic lastTrap = 1'b0;
	int killLeft = 0;
	int numChecks = 0;

	tbClock i_clk (.clk(clk), .nrst(nrst));

	exeTop #(.killCycles(killCycles)) i_dut (.*);

	// fibonacci lfsr with taps 32 22 2 1
	function automatic word_t randBits(input int n);
		word_t r;
		logic fb;
		int i;
		r = '0;
		for (i = 0; i < n; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic compareModel(input aluFn_t fn, input word_t a, input word_t b);
		case (fn)
			ALU_EQ: return a == b;
			ALU_LT: return (a[31] != b[31]) ? a[31] : (a < b); // sign bits decide first
			ALU_LTU: return a < b;
			default: return 1'b0;
		endcase
	endfunction

	function automatic word_t aluModel(input aluFn_t fn, input word_t a, input word_t b);
		case (fn)
			ALU_ADD: return a + b;
			ALU_SUB: return a + ~b + 32'd1;
			ALU_SLL: return a << b[4:0];
			ALU_SLT, ALU_LT: return word_t'(compareModel(ALU_LT, a, b));
			ALU_SLTU, ALU_LTU: return word_t'(compareModel(ALU_LTU, a, b));
			ALU_XOR: return a ^ b;
			ALU_SRL: return a >> b[4:0];
			ALU_SRA: return (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffffffff >> b[4:0]));
			ALU_OR: return a | b;
			ALU_AND: return a & b;
			ALU_EQ: return word_t'(compareModel(ALU_EQ, a, b));
			default: return '0;
		endcase
	endfunction

	function automatic entry_t makeEntry();
		entry_t e;
		e = '0;
		case (wbSel)
			WB_ALU: e.wbData = aluModel(aluFn, opA, opB);
			WB_LINK: e.wbData = pc + 32'd4;
			WB_UPPER: e.wbData = uImm;
			default: e.wbData = pc + uImm;
		endcase
		e.pc = pc;
		e.rd = rd;
		e.we = we;
		{e.ecall, e.illegal, e.misaligned, e.mret} = {ecall, illegal, instrMisaligned, mret};
		e.isBj = isBranch || isJump || isJumpReg;
		e.bjTaken = (isBranch && (compareModel(aluFn, opA, opB) != branchNe)) ||
			isJump || isJumpReg;
		if (isJumpReg)
		begin
			e.target = opA + opB;
			e.target[0] = 1'b0;
		end
		else
			e.target = pc + (isJump ? jImm : bImm);
		return e;
	endfunction

	// M ext first, then S ext, M timer, S timer and the stage-6 exceptions
	function automatic cause_t causeModel(input entry_t s6);
		logic sOk;
		sOk = (mode != MODE_M);
		if (mEie && mExt)
			return {1'b1, M_INT_EXT};
		if (sOk && sEie && sExt)
			return {1'b1, S_INT_EXT};
		if (mTie && mTimer)
			return {1'b1, M_INT_TIMER};
		if (sOk && sTie && sTimer)
			return {1'b1, S_INT_TIMER};
		if (s6.misaligned)
			return {1'b0, I_ADDR_MISALIGNED};
		if (s6.ecall)
			return cause_t'(U_CALL) + cause_t'(mode);
		if (s6.illegal)
			return {1'b0, I_ILLEGAL};
		return '0;
	endfunction

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkWord(input word_t got, input word_t exp, input string what);
		numChecks++;
		if (got !== exp)
			failRun($sformatf("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic checkReg(input regAddr_t got, input regAddr_t exp, input string what);
		numChecks++;
		if (got !== exp)
			failRun($sformatf("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic checkCause(input cause_t got, input cause_t exp, input string what);
		numChecks++;
		if (got !== exp)
			failRun($sformatf("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic checkBit(input logic got, input logic exp, input string what);
		numChecks++;
		if (got !== exp)
			failRun($sformatf("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic checkOutputs();
		entry_t s6, s5;
		cause_t expCause;
		logic expTrap;
		s6 = pipe[0];
		s5 = pipe[1];
		expCause = causeModel(s6);
		expTrap = expCause[31] || s6.ecall || s6.illegal || s6.misaligned || s6.mret;
		checkBit(trap, expTrap, "trap");
		checkCause(mcause, expCause, "mcause");
		checkBit(weOut, s6.we && !expTrap, "weOut");
		checkWord(wbData, s6.wbData, "wbData");
		checkReg(rdOut, s6.rd, "rdOut");
		checkWord(excPc, s6.pc, "excPc");
		checkBit(mretOut, s6.mret, "mretOut");
		checkBit(bjTaken, s5.bjTaken, "bjTaken");
		if (s5.isBj)
			checkWord(target, s5.target, "target");
		lastTrap = expTrap;
	endtask

	// one edge of the model with stage 6 zeroed on a trap and through the kill window
	task automatic advanceModel();
		logic flush;
		flush = lastTrap || (killLeft > 0);
		if (killLeft > 0)
			killLeft = killLeft - 1;
		else if (lastTrap)
			killLeft = killCycles;
		void'(pipe.pop_front());
		if (flush)
			pipe[0] = '0;
		pipe.push_back(makeEntry());
	endtask

	task automatic randomInputs();
		int kind;
		int m;
		kind = randBits(3);
		opA = randBits(32);
		opB = randBits(32);
		if (randBits(3) == 0)
			opB = opA; // equal operands for eq branches
		bImm = randBits(32);
		jImm = randBits(32);
		uImm = randBits(20) << 12;
		pc = randBits(30) << 2;
		rd = randBits(5);
		we = randBits(1);
		aluFn = aluFn_t'(randBits(4) % 13);
		wbSel = WB_ALU;
		{isBranch, branchNe, isJump, isJumpReg} = '0;
		case (kind)
			5:
			begin
				isBranch = 1'b1;
				branchNe = randBits(1);
				aluFn = aluFn_t'(int'(ALU_EQ) + randBits(2) % 3);
			end
			6:
			begin
				isJump = randBits(1);
				isJumpReg = !isJump;
				wbSel = WB_LINK;
			end
			7: wbSel = wbSel_t'(randBits(2) % 3 + 1);
			default: ;
		endcase
		{instrMisaligned, ecall, illegal, mret} = '0;
		if (randBits(5) == 0)
			{instrMisaligned, ecall, illegal, mret} = 4'b0001 << randBits(2); // one flag only
		{mTimer, sTimer, mExt, sExt} = '0;
		if (randBits(6) == 0)
			{mTimer, sTimer, mExt, sExt} = 4'b0001 << randBits(2);
		{mTie, sTie, mEie, sEie} = randBits(4);
		m = randBits(2);
		mode = (m == 2) ? MODE_M : mode_t'(m);
	endtask

	initial
	begin
		int waited;
		{opA, opB, bImm, jImm, uImm, pc, rd} = '0;
		{we, isBranch, branchNe, isJump, isJumpReg, instrMisaligned, ecall, illegal, mret} = '0;
		aluFn = ALU_ADD;
		wbSel = WB_ALU;
		mode = MODE_M;
		{mTimer, sTimer, mExt, sExt, mTie, sTie, mEie, sEie} = '0;
		pipe.push_back('0);
		pipe.push_back('0);
		waited = 0;
		while (nrst !== 1'b1)
		begin
			if (waited > 40)
				failRun("reset was not released within 40 clock cycles");
			@(posedge clk);
			waited++;
		end
		@(posedge clk);
		#1;
		for (int i = 0; i < numInstr; i++)
		begin
			randomInputs();
			@(negedge clk);
			checkOutputs();
			@(posedge clk);
			advanceModel();
			#1;
		end
		if (numChecks > 0)
		begin
			$display("TEST PASS");
			$finish;
		end
		else
		begin
			$display("TEST FAIL");
			$fatal(1, "no checks were run");
		end
	end

endmodule

//--- sources.f
exePkg.sv
alu.sv
exeStage.sv
retireReg.sv
commitStage.sv
exeTop.sv
tbClock.sv
exeTb.sv

//--- Bender.yml
package:
  name: exe_commit

sources:
  - exePkg.sv
  - alu.sv
  - exeStage.sv
  - retireReg.sv
  - commitStage.sv
  - exeTop.sv
  - target: test
    files:
      - tbClock.sv
      - exeTb.sv
